/* aw_monitor_params.svh */
`ifndef AW_MONITOR_PARAMS_SVH
`define AW_MONITOR_PARAMS_SVH

// --------------------
// Monitor sizing
// --------------------

// Number of AW channels watched in parallel
`define AW_NUM_PORTS 4

// AXI address bus width
`define AW_ADDR_WIDTH 32

// AXI transaction ID width
`define AW_ID_WIDTH 4

// Data bus width in bytes
// Only the test traffic uses it
`define AW_DATA_BYTES 4

// Width of each per-rule violation counter
`define AW_CNT_WIDTH 16

`endif

/* axi4_types_pkg.sv */
`include "aw_monitor_params.svh"

package axi4_types_pkg;

  // --------------------
  // Burst encodings
  // --------------------

  // AXI4 AWBURST field, 2'b11 is reserved
  typedef enum logic [1:0] {
    FIXED    = 2'b00,
    INCR     = 2'b01,
    WRAP     = 2'b10,
    RESERVED = 2'b11
  } aw_burst_e;

  // --------------------
  // AW channel
  // --------------------

  // Address phase fields, everything except the handshake
  // Width is ID plus address plus 18 bits
  typedef struct packed {
    logic [`AW_ID_WIDTH-1:0]   id;
    logic [`AW_ADDR_WIDTH-1:0] addr;
    logic [3:0]                len;
    logic [2:0]                size;
    aw_burst_e                 burst;
    logic [1:0]                lock;
    logic [3:0]                cache;
    logic [2:0]                prot;
  } aw_payload_t;

  // One observed AW channel with its handshake pair
  typedef struct packed {
    aw_payload_t payload;
    logic        valid;
    logic        ready;
  } aw_chan_t;

endpackage

/* aw_check_pkg.sv */
`include "aw_monitor_params.svh"

package aw_check_pkg;

  // --------------------
  // Rule flags
  // --------------------

  // Rule index, also the bit position inside aw_viol_t
  typedef enum logic [2:0] {
    RULE_PAYLOAD_CHANGE = 3'd0,
    RULE_VALID_DROP     = 3'd1,
    RULE_BAD_BURST      = 3'd2,
    RULE_BAD_WRAP_LEN   = 3'd3,
    RULE_WRAP_MISALIGN  = 3'd4,
    RULE_CROSS_4K       = 3'd5
  } aw_rule_e;

  // Counter array depth
  localparam int AW_NUM_RULES = int'(RULE_CROSS_4K) + 1;

  // Port field width, never below one bit
  localparam int AW_PORT_WIDTH = (`AW_NUM_PORTS > 1) ? $clog2(`AW_NUM_PORTS) : 1;

  // Fields listed MSB first so payload_change lands on bit 0
  typedef struct packed {
    logic cross_4k;
    logic wrap_misalign;
    logic bad_wrap_len;
    logic bad_burst;
    logic valid_drop;
    logic payload_change;
  } aw_viol_t;

  // First violation seen since reset
  typedef struct packed {
    logic                     valid;
    logic [AW_PORT_WIDTH-1:0] port;
    aw_viol_t                 flags;
    logic [`AW_ID_WIDTH-1:0]  id;
  } aw_first_err_t;

  // Sampler output for one channel
  typedef struct packed {
    axi4_types_pkg::aw_chan_t cur;
    axi4_types_pkg::aw_chan_t prev;
    logic                     stalled;
  } aw_sample_t;

endpackage

/* aw_port_sampler.sv */
`timescale 1ns/100ps
`include "aw_monitor_params.svh"

module aw_port_sampler (
  input  logic                                          aclk,
  input  logic                                          reset,
  input  axi4_types_pkg::aw_chan_t [`AW_NUM_PORTS-1:0]  aw_bus,
  output aw_check_pkg::aw_sample_t [`AW_NUM_PORTS-1:0]  sample
);

  // --------------------
  // Two-deep history per port
  // --------------------

  // cur holds the beat taken at this edge
  // prev holds the beat from the edge before
  // stalled says prev was waiting on ready
  always_ff @(posedge aclk) begin
    for (int p = 0; p < `AW_NUM_PORTS; p++) begin
      // Payload words carry no reset
      sample[p].cur.payload  <= aw_bus[p].payload;
      sample[p].prev.payload <= sample[p].cur.payload;

      if (reset) begin
        // Handshake history cleared
        sample[p].cur.valid  <= 1'b0;
        sample[p].cur.ready  <= 1'b0;
        sample[p].prev.valid <= 1'b0;
        sample[p].prev.ready <= 1'b0;
        // No stall right after reset
        sample[p].stalled    <= 1'b0;
      end else begin
        sample[p].cur.valid  <= aw_bus[p].valid;
        sample[p].cur.ready  <= aw_bus[p].ready;
        sample[p].prev.valid <= sample[p].cur.valid;
        sample[p].prev.ready <= sample[p].cur.ready;
        // Beat now moving to prev was held off by the slave
        sample[p].stalled    <= sample[p].cur.valid & ~sample[p].cur.ready;
      end
    end
  end

endmodule

/* aw_rule_checker.sv */
`timescale 1ns/100ps
`include "aw_monitor_params.svh"

module aw_rule_checker (
  input  logic                     aclk,
  input  logic                     reset,
  input  aw_check_pkg::aw_sample_t sample,
  output aw_check_pkg::aw_viol_t   viol
);

  // --------------------
  // Decoded beat
  // --------------------

  axi4_types_pkg::aw_payload_t cur_pl;
  axi4_types_pkg::aw_payload_t prev_pl;

  // Handshake on the current beat
  logic handshake;

  // Burst type decode
  logic is_wrap;
  logic is_incr;

  // Low address bits that must be zero for a given size
  logic [7:0] align_mask;

  // Offset inside the 4 KB page and bytes moved by the burst
  logic [12:0] page_offset;
  logic [12:0] xfer_bytes;
  logic [12:0] burst_end;

  aw_check_pkg::aw_viol_t viol_d;

  assign cur_pl    = sample.cur.payload;
  assign prev_pl   = sample.prev.payload;
  assign handshake = sample.cur.valid & sample.cur.ready;

  assign is_wrap = (cur_pl.burst == axi4_types_pkg::WRAP);
  assign is_incr = (cur_pl.burst == axi4_types_pkg::INCR);

  // 2^size minus one, size tops out at 128 bytes
  assign align_mask = (8'd1 << cur_pl.size) - 8'd1;

  // (len + 1) beats of 2^size bytes, at most 2048
  assign page_offset = {1'b0, cur_pl.addr[11:0]};
  assign xfer_bytes  = ({9'd0, cur_pl.len} + 13'd1) << cur_pl.size;
  assign burst_end   = page_offset + xfer_bytes;

  // --------------------
  // Rule evaluation
  // --------------------

  always_comb begin
    viol_d = '0;

    // Stability rules only apply while the previous beat was stalled
    if (sample.stalled) begin
      if (!sample.cur.valid) begin
        viol_d.valid_drop = 1'b1;
      end else if (cur_pl != prev_pl) begin
        viol_d.payload_change = 1'b1;
      end
    end

    // Burst legality at the accepting edge
    if (handshake) begin
      viol_d.bad_burst = (cur_pl.burst == axi4_types_pkg::RESERVED);

      // WRAP takes 2, 4, 8 or 16 beats
      viol_d.bad_wrap_len = is_wrap &&
                            !(cur_pl.len inside {4'd1, 4'd3, 4'd7, 4'd15});

      // WRAP start aligned to the beat size
      viol_d.wrap_misalign = is_wrap &&
                             ((cur_pl.addr[7:0] & align_mask) != 8'd0);

      // Last byte still inside the start page
      viol_d.cross_4k = is_incr && (burst_end > 13'd4096);
    end
  end

  // One-cycle pulses, one edge after the sample
  always_ff @(posedge aclk) begin
    if (reset) begin
      viol <= '0;
    end else begin
      viol <= viol_d;
    end
  end

endmodule

/* aw_violation_log.sv */
`timescale 1ns/100ps
`include "aw_monitor_params.svh"

module aw_violation_log (
  input  logic                                                     aclk,
  input  logic                                                     reset,
  input  aw_check_pkg::aw_viol_t [`AW_NUM_PORTS-1:0]              viol_in,
  // Sampler record, prev holds the beat behind viol_in
  input  aw_check_pkg::aw_sample_t [`AW_NUM_PORTS-1:0]            sample_in,
  output aw_check_pkg::aw_viol_t [`AW_NUM_PORTS-1:0]              viol,
  output logic [aw_check_pkg::AW_NUM_RULES-1:0][`AW_CNT_WIDTH-1:0] err_count,
  output aw_check_pkg::aw_first_err_t                              first_err,
  output logic                                                     err_any
);

  localparam int NUM_RULES = aw_check_pkg::AW_NUM_RULES;
  localparam int CNT_W     = `AW_CNT_WIDTH;
  localparam int HIT_W     = $clog2(`AW_NUM_PORTS + 1);
  localparam int PORT_W    = aw_check_pkg::AW_PORT_WIDTH;

  logic [NUM_RULES-1:0][HIT_W-1:0] hits;
  logic [NUM_RULES-1:0][CNT_W:0]   cnt_sum;
  logic [PORT_W-1:0]               sel_port;
  logic                            any_flag;

  // Pulses pass straight through
  assign viol = viol_in;

  // --------------------
  // Flag reduction
  // --------------------

  // Ports flagging each rule this cycle
  // Bit r of a flag word is rule r
  always_comb begin
    hits = '0;
    for (int p = 0; p < `AW_NUM_PORTS; p++) begin
      for (int r = 0; r < NUM_RULES; r++) begin
        hits[r] = hits[r] + HIT_W'(viol_in[p][r]);
      end
    end
  end

  // Lowest flagging port wins, scan from the top down
  always_comb begin
    sel_port = '0;
    any_flag = 1'b0;
    for (int p = `AW_NUM_PORTS - 1; p >= 0; p--) begin
      if (|viol_in[p]) begin
        sel_port = PORT_W'(p);
        any_flag = 1'b1;
      end
    end
  end

  // Extra top bit catches overflow
  always_comb begin
    for (int r = 0; r < NUM_RULES; r++) begin
      cnt_sum[r] = {1'b0, err_count[r]} + (CNT_W + 1)'(hits[r]);
    end
  end

  // --------------------
  // Log state
  // --------------------

  always_ff @(posedge aclk) begin
    if (reset) begin
      err_count <= '0;
      first_err <= '0;
      err_any   <= 1'b0;
    end else begin
      // Saturate at all ones
      for (int r = 0; r < NUM_RULES; r++) begin
        err_count[r] <= cnt_sum[r][CNT_W] ? {CNT_W{1'b1}} : cnt_sum[r][CNT_W-1:0];
      end

      // Record held until reset
      if (any_flag && !first_err.valid) begin
        first_err.valid <= 1'b1;
        first_err.port  <= sel_port;
        first_err.flags <= viol_in[sel_port];
        first_err.id    <= sample_in[sel_port].prev.payload.id;
      end

      err_any <= err_any | any_flag;
    end
  end

endmodule

/* axi_aw_monitor.sv */
`timescale 1ns/100ps
`include "aw_monitor_params.svh"

module axi_aw_monitor (
  input  logic                                                     aclk,
  input  logic                                                     reset,
  input  axi4_types_pkg::aw_chan_t [`AW_NUM_PORTS-1:0]            aw_bus,
  output aw_check_pkg::aw_viol_t [`AW_NUM_PORTS-1:0]              viol,
  output logic [aw_check_pkg::AW_NUM_RULES-1:0][`AW_CNT_WIDTH-1:0] err_count,
  output aw_check_pkg::aw_first_err_t                              first_err,
  output logic                                                     err_any
);

  // --------------------
  // Pipeline wires
  // --------------------

  // Stage 1, registered beats with history
  aw_check_pkg::aw_sample_t [`AW_NUM_PORTS-1:0] sample;

  // Stage 2, registered per-port rule flags
  aw_check_pkg::aw_viol_t [`AW_NUM_PORTS-1:0] chk_viol;

  // Samples every channel at each edge
  aw_port_sampler u_sampler (
    .aclk   (aclk),
    .reset  (reset),
    .aw_bus (aw_bus),
    .sample (sample)
  );

  // One rule checker per channel
  for (genvar p = 0; p < `AW_NUM_PORTS; p++) begin : g_chk
    aw_rule_checker u_checker (
      .aclk   (aclk),
      .reset  (reset),
      .sample (sample[p]),
      .viol   (chk_viol[p])
    );
  end

  // Counters, first error and sticky level
  aw_violation_log u_log (
    .aclk      (aclk),
    .reset     (reset),
    .viol_in   (chk_viol),
    .sample_in (sample),
    .viol      (viol),
    .err_count (err_count),
    .first_err (first_err),
    .err_any   (err_any)
  );

endmodule

/* axi_aw_monitor_chk.sv */
`timescale 1ns/100ps
`include "aw_monitor_params.svh"

module axi_aw_monitor_chk (
  input logic                                                     aclk,
  input logic                                                     reset,
  input aw_check_pkg::aw_viol_t [`AW_NUM_PORTS-1:0]               viol,
  input logic [aw_check_pkg::AW_NUM_RULES-1:0][`AW_CNT_WIDTH-1:0] err_count,
  input aw_check_pkg::aw_first_err_t                              first_err,
  input logic                                                     err_any
);

  // --------------------
  // Log consistency
  // --------------------

  // Sticky level never ahead of the record
  a_any_has_first: assert property (@(posedge aclk) disable iff (reset)
    err_any |-> first_err.valid)
    else $error("err_any set with no first error record");

  // Counters only climb between resets
  for (genvar r = 0; r < aw_check_pkg::AW_NUM_RULES; r++) begin : g_cnt
    a_cnt_rises: assert property (@(posedge aclk) disable iff (reset)
      !$past(reset) |-> err_count[r] >= $past(err_count[r]))
      else $error("counter %0d decreased", r);
  end

  // Record frozen once taken
  a_first_hold: assert property (@(posedge aclk) disable iff (reset)
    (!$past(reset) && $past(first_err.valid)) |-> first_err == $past(first_err))
    else $error("first_err changed after it was valid");

  // Pipeline still empty two cycles out of reset
  a_quiet_after_reset: assert property (@(posedge aclk) disable iff (reset)
    ($past(reset) || $past(reset, 2)) |-> viol == '0)
    else $error("viol set right after reset");

endmodule

/* tb_axi_aw_monitor.sv */
`timescale 1ns/100ps
`include "aw_monitor_params.svh"

module tb_axi_aw_monitor;

  localparam int NP = `AW_NUM_PORTS;
  localparam int NR = aw_check_pkg::AW_NUM_RULES;
  localparam int CW = `AW_CNT_WIDTH;

  typedef aw_check_pkg::aw_viol_t [NP-1:0] viol_vec_t;
  typedef logic [NP-1:0][`AW_ID_WIDTH-1:0] id_vec_t;

  logic                              aclk;
  logic                              reset;
  axi4_types_pkg::aw_chan_t [NP-1:0] aw_bus;
  viol_vec_t                         viol;
  logic [NR-1:0][CW-1:0]             err_count;
  aw_check_pkg::aw_first_err_t       first_err;
  logic                              err_any;

  // Scoreboard state
  viol_vec_t                         exp_q[$];
  id_vec_t                           id_q[$];
  axi4_types_pkg::aw_chan_t [NP-1:0] prev_bus;
  logic [NR-1:0][CW-1:0]             exp_count;
  aw_check_pkg::aw_first_err_t       exp_first;
  int                                n_checks;
  int                                n_errors;
  int                                test_base;

  axi_aw_monitor UUT (
    .aclk      (aclk),
    .reset     (reset),
    .aw_bus    (aw_bus),
    .viol      (viol),
    .err_count (err_count),
    .first_err (first_err),
    .err_any   (err_any)
  );

  bind axi_aw_monitor axi_aw_monitor_chk u_chk (.*);

  always #10 aclk = ~aclk;

  // --------------------
  // Reference model
  // --------------------

  // Expected flags for one port from its previous and current bus value
  function automatic aw_check_pkg::aw_viol_t aw_expect(input axi4_types_pkg::aw_chan_t prev,
                                                      input axi4_types_pkg::aw_chan_t cur);
    aw_check_pkg::aw_viol_t v;
    int unsigned beat_bytes;
    int unsigned beats;
    int unsigned offset;
    v = '0;
    beat_bytes = 32'd1 << cur.payload.size;
    beats = int'(cur.payload.len) + 1;
    offset = cur.payload.addr % 32'd4096;
    // Beat was held off, so it must stay put
    if (prev.valid && !prev.ready) begin
      if (!cur.valid) v.valid_drop = 1'b1;
      else if (cur.payload != prev.payload) v.payload_change = 1'b1;
    end
    if (cur.valid && cur.ready) begin
      v.bad_burst = (cur.payload.burst == axi4_types_pkg::RESERVED);
      if (cur.payload.burst == axi4_types_pkg::WRAP) begin
        v.bad_wrap_len = !(beats == 2 || beats == 4 || beats == 8 || beats == 16);
        v.wrap_misalign = (cur.payload.addr % beat_bytes) != 0;
      end
      if (cur.payload.burst == axi4_types_pkg::INCR) begin
        v.cross_4k = (offset + beats * beat_bytes) > 4096;
      end
    end
    return v;
  endfunction

  // Running counts and first record, fed in DUT order
  task automatic tally(input viol_vec_t v, input id_vec_t ids);
    int sum;
    for (int r = 0; r < NR; r++) begin
      sum = int'(exp_count[r]);
      for (int p = 0; p < NP; p++) sum += int'(v[p][r]);
      exp_count[r] = (sum > (1 << CW) - 1) ? '1 : CW'(sum);
    end
    // Ascending scan, lowest port wins
    for (int p = 0; p < NP; p++) begin
      if (!exp_first.valid && (|v[p])) begin
        exp_first.valid = 1'b1;
        exp_first.port  = aw_check_pkg::AW_PORT_WIDTH'(p);
        exp_first.flags = v[p];
        exp_first.id    = ids[p];
      end
    end
  endtask

  // --------------------
  // Compare tasks
  // --------------------

  task automatic check_viol(input int port, input aw_check_pkg::aw_viol_t got,
                            input aw_check_pkg::aw_viol_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail %0t: port %0d viol %b, expected %b", $time, port, got, exp);
    end
  endtask

  task automatic check_count(input aw_check_pkg::aw_rule_e rule, input logic [CW-1:0] exp);
    n_checks++;
    if (err_count[rule] !== exp) begin
      n_errors++;
      $display("Fail %0t: count %s is %0d, expected %0d", $time, rule.name(),
               err_count[rule], exp);
    end
  endtask

  task automatic check_first(input aw_check_pkg::aw_first_err_t exp);
    n_checks++;
    if (first_err !== exp) begin
      n_errors++;
      $display("Fail %0t: first_err %h, expected %h", $time, first_err, exp);
    end
  endtask

  task automatic check_level(input logic exp);
    n_checks++;
    if (err_any !== exp) begin
      n_errors++;
      $display("Fail %0t: err_any %b, expected %b", $time, err_any, exp);
    end
  endtask

  // Two cycles from bus to viol, checked on the falling edge
  always @(negedge aclk) begin
    viol_vec_t exp_v;
    id_vec_t   ids;
    if (reset) begin
      exp_q.delete();
      id_q.delete();
      exp_q.push_back('0);
      id_q.push_back('0);
      prev_bus  = '0;
      exp_count = '0;
      exp_first = '0;
    end else begin
      for (int p = 0; p < NP; p++) begin
        exp_v[p] = aw_expect(prev_bus[p], aw_bus[p]);
        ids[p]   = aw_bus[p].payload.id;
      end
      exp_q.push_back(exp_v);
      id_q.push_back(ids);
      prev_bus = aw_bus;
    end
    if (exp_q.size() > 2) begin
      exp_v = exp_q.pop_front();
      ids   = id_q.pop_front();
      for (int p = 0; p < NP; p++) check_viol(p, viol[p], exp_v[p]);
      tally(exp_v, ids);
    end
  end

  // --------------------
  // Stimulus helpers
  // --------------------

  // Aligned WRAP or INCR inside its 4 KB page
  function automatic axi4_types_pkg::aw_payload_t legal_payload();
    axi4_types_pkg::aw_payload_t pl;
    int unsigned bytes;
    pl.id    = `AW_ID_WIDTH'($urandom);
    pl.size  = 3'($urandom % ($clog2(`AW_DATA_BYTES) + 1));
    pl.lock  = 2'($urandom);
    pl.cache = 4'($urandom);
    pl.prot  = 3'($urandom);
    if ($urandom % 2 == 0) begin
      pl.burst = axi4_types_pkg::WRAP;
      pl.len   = 4'((32'd2 << ($urandom % 4)) - 1);
    end else begin
      pl.burst = axi4_types_pkg::INCR;
      pl.len   = 4'($urandom);
    end
    bytes = (int'(pl.len) + 1) << pl.size;
    pl.addr = `AW_ADDR_WIDTH'($urandom);
    pl.addr[11:0] = 12'($urandom % (4097 - bytes));
    pl.addr = pl.addr & ~((`AW_ADDR_WIDTH'(1) << pl.size) - 1);
    return pl;
  endfunction

  function automatic axi4_types_pkg::aw_payload_t random_payload();
    axi4_types_pkg::aw_payload_t pl;
    pl = legal_payload();
    pl.addr  = `AW_ADDR_WIDTH'($urandom);
    pl.len   = 4'($urandom);
    pl.size  = 3'($urandom);
    pl.burst = axi4_types_pkg::aw_burst_e'(2'($urandom));
    return pl;
  endfunction

  // Poll one flag, give up after eight cycles
  task automatic wait_flag(input int port, input aw_check_pkg::aw_rule_e rule);
    int waited;
    waited = 0;
    @(negedge aclk);
    while (!viol[port][rule] && waited < 8) begin
      waited++;
      @(negedge aclk);
    end
    if (!viol[port][rule]) begin
      $display("Timeout: port %0d never flagged %s", port, rule.name());
      $display("sim failed");
      $finish;
    end
  endtask

  // Finish stalled beats, go idle, let the pipe drain, then compare state
  task automatic finish_test(input string name);
    @(posedge aclk);
    for (int p = 0; p < NP; p++) begin
      if (aw_bus[p].valid) aw_bus[p].ready <= 1'b1;
    end
    @(posedge aclk);
    for (int p = 0; p < NP; p++) begin
      aw_bus[p].valid <= 1'b0;
      aw_bus[p].ready <= 1'b0;
    end
    repeat (5) @(posedge aclk);
    for (int r = 0; r < NR; r++) check_count(aw_check_pkg::aw_rule_e'(r), exp_count[r]);
    check_first(exp_first);
    check_level(exp_first.valid);
    $display("%s done, %0d errors", name, n_errors - test_base);
    test_base = n_errors;
  endtask

  task automatic hold_reset();
    @(posedge aclk);
    reset <= 1'b1;
    repeat (10) @(posedge aclk);
    reset <= 1'b0;
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    axi4_types_pkg::aw_payload_t pl;
    void'($urandom(32'h84cc));
    aclk = 1'b0;
    reset = 1'b1;
    aw_bus = '0;
    prev_bus = '0;
    exp_count = '0;
    exp_first = '0;
    n_checks = 0;
    n_errors = 0;
    test_base = 0;
    hold_reset();

    // Legal traffic, payload held through random stalls
    for (int c = 0; c < 300; c++) begin
      @(posedge aclk);
      for (int p = 0; p < NP; p++) begin
        if (aw_bus[p].valid && !aw_bus[p].ready) begin
          aw_bus[p].ready <= 1'($urandom % 3 == 0);
        end else begin
          aw_bus[p].payload <= legal_payload();
          aw_bus[p].valid   <= 1'($urandom);
          aw_bus[p].ready   <= 1'($urandom);
        end
      end
    end
    finish_test("legal traffic");

    // Payload change on port 1, then valid drop on port 2
    pl = legal_payload();
    @(posedge aclk);
    aw_bus[1] <= '{payload: pl, valid: 1'b1, ready: 1'b0};
    pl.id = pl.id + 1'b1;
    @(posedge aclk);
    aw_bus[1].payload <= pl;
    wait_flag(1, aw_check_pkg::RULE_PAYLOAD_CHANGE);
    @(posedge aclk);
    aw_bus[1].ready <= 1'b1;
    aw_bus[2] <= '{payload: pl, valid: 1'b1, ready: 1'b0};
    @(posedge aclk);
    aw_bus[1].valid <= 1'b0;
    aw_bus[2].valid <= 1'b0;
    wait_flag(2, aw_check_pkg::RULE_VALID_DROP);
    finish_test("stall rules");

    // Random beats on every port; counters follow the model totals
    for (int c = 0; c < 400; c++) begin
      @(posedge aclk);
      for (int p = 0; p < NP; p++) begin
        aw_bus[p] <= '{payload: random_payload(), valid: 1'($urandom % 4 != 0),
                       ready: 1'($urandom)};
      end
    end
    finish_test("random beats and counters");

    // Reset with port 0 stalled, payload changed while in reset
    @(posedge aclk);
    aw_bus[0] <= '{payload: legal_payload(), valid: 1'b1, ready: 1'b0};
    hold_reset();
    aw_bus[0].payload <= legal_payload();
    repeat (4) @(posedge aclk);
    check_first('0);
    check_level(1'b0);
    for (int r = 0; r < NR; r++) check_count(aw_check_pkg::aw_rule_e'(r), '0);
    finish_test("mid-run reset");

    // Same-cycle violations on ports 2 and 3, a later one on port 0
    pl = legal_payload();
    pl.burst = axi4_types_pkg::WRAP;
    pl.len   = 4'd2;
    pl.addr  = '0;
    @(posedge aclk);
    aw_bus[0] <= '{payload: legal_payload(), valid: 1'b1, ready: 1'b1};
    aw_bus[1] <= '{payload: legal_payload(), valid: 1'b1, ready: 1'b1};
    aw_bus[2] <= '{payload: pl, valid: 1'b1, ready: 1'b1};
    pl.burst = axi4_types_pkg::RESERVED;
    pl.id = pl.id + 1'b1;
    aw_bus[3] <= '{payload: pl, valid: 1'b1, ready: 1'b1};
    @(posedge aclk);
    for (int p = 0; p < NP; p++) aw_bus[p].valid <= 1'b0;
    wait_flag(2, aw_check_pkg::RULE_BAD_WRAP_LEN);
    @(posedge aclk);
    aw_bus[0] <= '{payload: pl, valid: 1'b1, ready: 1'b1};
    finish_test("first error record");

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+.
axi4_types_pkg.sv
aw_check_pkg.sv
aw_port_sampler.sv
aw_rule_checker.sv
aw_violation_log.sv
axi_aw_monitor.sv
axi_aw_monitor_chk.sv
tb_axi_aw_monitor.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tb_axi_aw_monitor -o tb_axi_aw_monitor
./obj_dir/tb_axi_aw_monitor | tee sim.log

if grep -qx "sim passed" sim.log; then
  exit 0
fi
exit 1
